//--- tests/lcd_video_tests.dat
# Test name, contrast and four frame seeds, all numbers in hex
# One test per line
full_bright   3f  00 11 22 33
sat_edge      20  a5 5a c3 3c
just_below    1f  ff 00 ff 00
mid_contrast  12  01 80 fe 7f
dim_contrast  03  40 41 42 43

//--- flist.f
+incdir+src
src/lcd_video_pkg.sv
src/frame_capture.sv
src/frame_store.sv
src/video_timing.sv
src/pixel_blender.sv
src/lcd_video_top.sv
tests/lcd_video_props.sv
tests/lcd_video_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --assert --timing --top-module lcd_video_tb -f flist.f -o lcd_video_sim &&
./obj_dir/lcd_video_sim || exit 1

//--- tests/lcd_video_tb.sv
`timescale 1ns/1ps

`include "lcd_video_cfg.svh"

module lcd_video_tb;
    import lcd_video_pkg::*;

    logic       clk_sys;
    logic       reset;
    logic       frame_complete;
    logic [5:0] lcd_contrast;
    lcd_addr_t  lcd_read;
    logic [7:0] lcd_read_column;
    logic       ce_pix;
    video_out_t video;

    // LCD model and reference copy of the four buffers
    logic [7:0] lcd_seed;
    logic [7:0] model_mem [`FB_COUNT][`FB_DEPTH];
    int         model_index;
    longint     cycle_count = 0;
    longint     cycle_limit = 0;
    string      test_names[$];
    logic [5:0] test_contrast[$];
    logic [7:0] test_seeds[$];

    lcd_video_top dut (.*);

    // Pattern byte of one LCD frame at a linear address
    function automatic logic [7:0] frame_byte(input logic [7:0] seed, input logic [9:0] addr);
        return seed + addr[7:0] + {addr[9:8], 6'd0};
    endfunction

    assign lcd_read_column = frame_byte(lcd_seed,
        10'(lcd_read.row) * 10'(`LCD_XSIZE) + 10'(lcd_read.col));

    initial
    begin
        clk_sys = 1'b0;
        forever
            #5 clk_sys = ~clk_sys;
    end

    always @(posedge clk_sys)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit != 0 && cycle_count >= cycle_limit)
            stop_with_error($sformatf("Timeout after %0d cycles, tests did not finish", cycle_count));
    end

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////

    task automatic stop_with_error(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1);
    endtask

    // Dark pixels add the brightness, then the four buffers are averaged
    function automatic logic [7:0] expected_level(input int x, input int y);
        int bright;
        int dark;
        dark = 0;
        bright = (lcd_contrast >= `CONTRAST_SAT) ? 255 : int'(lcd_contrast) * 8;
        for (int b = 0; b < `FB_COUNT; b++)
            if (!model_mem[b][(y / 8) * `LCD_XSIZE + x][y % 8])
                dark++;
        return 8'((bright * dark) / 4);
    endfunction

    // Falling edge just before the next pixel enable edge, gap in clocks waited
    task automatic next_pixel(output int gap);
        gap = 1;
        @(negedge clk_sys);
        while (!ce_pix)
        begin
            gap++;
            @(negedge clk_sys);
        end
    endtask

    task automatic copy_frame(input logic [7:0] seed);
        lcd_seed = seed;
        frame_complete = 1'b1;
        @(negedge clk_sys);
        frame_complete = 1'b0;
        // Copy of 768 bytes ends within 1537 cycles of the strobe
        repeat (1537)
            @(negedge clk_sys);
        for (int a = 0; a < `FB_DEPTH; a++)
            model_mem[model_index][a] = frame_byte(seed, 10'(a));
        model_index = (model_index + 1) % `FB_COUNT;
    endtask

    // One raster frame starting after a vsync rising edge
    task automatic scan_frame(input string name, input logic check_level);
        int         de_total;
        int         de_runs;
        int         run_len;
        int         hs_rises;
        int         vs_rises;
        int         gap;
        video_out_t prev;
        logic [7:0] want;
        de_total = 0;
        de_runs = 0;
        run_len = 0;
        hs_rises = 0;
        vs_rises = 0;
        do
        begin
            prev = video;
            next_pixel(gap);
        end
        while (!video.sync.vs || prev.sync.vs);
        for (int i = 0; i < `H_TOTAL * `V_TOTAL; i++)
        begin
            prev = video;
            next_pixel(gap);
            assert (gap == 4)
                else stop_with_error($sformatf("[FAIL] %s: ce_pix period expected 4, actual %0d",
                    name, gap));
            hs_rises += int'(video.sync.hs && !prev.sync.hs);
            vs_rises += int'(video.sync.vs && !prev.sync.vs);
            assert (!video.de || (!video.sync.hbl && !video.sync.vbl))
                else stop_with_error($sformatf("[FAIL] %s: hbl/vbl during de expected 0/0, actual %0d/%0d",
                    name, video.sync.hbl, video.sync.vbl));
            if (video.de && !prev.de)
            begin
                de_runs++;
                run_len = 0;
            end
            if (video.de && check_level && de_total < `LCD_XSIZE * `LCD_YSIZE)
            begin
                want = expected_level(de_total % `LCD_XSIZE, de_total / `LCD_XSIZE);
                assert (video.level == want)
                    else stop_with_error($sformatf(
                        "[FAIL] %s: level at pixel %0d expected %0d, actual %0d",
                        name, de_total, want, video.level));
            end
            de_total += int'(video.de);
            run_len += int'(video.de);
            assert (video.de || !prev.de || run_len == `LCD_XSIZE)
                else stop_with_error($sformatf(
                    "[FAIL] %s: de pixels per line expected %0d, actual %0d",
                    name, `LCD_XSIZE, run_len));
        end
        assert (de_total == `LCD_XSIZE * `LCD_YSIZE && de_runs == `LCD_YSIZE)
            else stop_with_error($sformatf(
                "[FAIL] %s: de pixels/lines expected %0d/%0d, actual %0d/%0d",
                name, `LCD_XSIZE * `LCD_YSIZE, `LCD_YSIZE, de_total, de_runs));
        assert (hs_rises == `V_TOTAL && vs_rises == 1)
            else stop_with_error($sformatf("[FAIL] %s: hs/vs pulses expected %0d/1, actual %0d/%0d",
                name, `V_TOTAL, hs_rises, vs_rises));
    endtask

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////

    initial
    begin
        int              fd;
        int              c;
        int              s [4];
        logic [8*24-1:0] name_v;
        string           line;
        void'($urandom(32'he758b781));
        reset = 1'b1;
        frame_complete = 1'b0;
        lcd_contrast = '0;
        lcd_seed = '0;
        model_index = 0;
        fd = $fopen("tests/lcd_video_tests.dat", "r");
        if (fd == 0)
            stop_with_error("Cannot open the test data file tests/lcd_video_tests.dat");
        while ($fgets(line, fd) != 0)
        begin
            if (line.len() < 2 || line.substr(0, 0) == "#")
                continue;
            if ($sscanf(line, "%s %h %h %h %h %h", name_v, c, s[0], s[1], s[2], s[3]) != 6)
                stop_with_error($sformatf("Malformed line in the test data file: %s", line));
            test_names.push_back($sformatf("%0s", name_v));
            test_contrast.push_back(6'(c));
            foreach (s[k])
                test_seeds.push_back(8'(s[k]));
        end
        $fclose(fd);
        // Seven frames per test at most, two more for reset and the first frame
        cycle_limit = (longint'(test_names.size()) * 7 + 2) * `H_TOTAL * `V_TOTAL * 4;

        repeat (5)
            @(negedge clk_sys);
        reset = 1'b0;
        while (!ce_pix)
        begin
            assert (!video.de && !video.sync.hs && !video.sync.vs
                    && video.sync.hbl && video.sync.vbl)
                else stop_with_error("Video de or sync not at its reset value before the first pixel enable");
            @(negedge clk_sys);
        end
        scan_frame("reset_frame", 1'b0);

        foreach (test_names[t])
        begin
            lcd_contrast = test_contrast[t];
            for (int f = 0; f < `FB_COUNT; f++)
                copy_frame(test_seeds[t * `FB_COUNT + f]);
            scan_frame(test_names[t], 1'b1);
            // One more copy replaces only the next buffer in turn
            copy_frame(8'($urandom));
            scan_frame({test_names[t], "_overwrite"}, 1'b1);
        end
        $display("Test completed successfully");
        $finish;
    end

endmodule

//--- tests/lcd_video_props.sv
`timescale 1ns/1ps

`include "lcd_video_cfg.svh"

module lcd_video_props
(
    input logic                      clk_sys,
    input logic                      reset,
    input lcd_video_pkg::lcd_addr_t  lcd_read,
    input lcd_video_pkg::video_out_t video
);

    // Data enable stays clear of the hsync pulse
    de_outside_hsync: assert property (@(posedge clk_sys) disable iff (reset)
        !(video.de && video.sync.hs))
        else $error("Data enable high during hsync");

    // Byte row is three bits wide, so only the column can leave the LCD
    lcd_read_in_range: assert property (@(posedge clk_sys) disable iff (reset)
        lcd_read.col < 7'(`LCD_XSIZE))
        else $error("LCD read column outside 96 columns");

    // Vsync only starts inside vertical blank
    vs_rise_in_vblank: assert property (@(posedge clk_sys) disable iff (reset)
        $rose(video.sync.vs) |-> video.sync.vbl)
        else $error("Vsync rose outside vertical blank");

endmodule

bind lcd_video_top lcd_video_props u_props
(
    .clk_sys  (clk_sys),
    .reset    (reset),
    .lcd_read (lcd_read),
    .video    (video)
);

//--- src/lcd_video_top.sv
`timescale 1ns/1ps

`include "lcd_video_cfg.svh"

module lcd_video_top
(
    input  logic                      clk_sys,
    input  logic                      reset,
    input  logic                      frame_complete,
    input  logic [5:0]                lcd_contrast,
    output lcd_video_pkg::lcd_addr_t  lcd_read,
    input  logic [7:0]                lcd_read_column,
    output logic                      ce_pix,
    output lcd_video_pkg::video_out_t video
);
    import lcd_video_pkg::*;

    // Capture to store
    logic       fb_we;
    lcd_addr_t  fb_wr_addr;
    logic [1:0] fb_wr_index;
    logic [7:0] fb_wr_data;

    // Timing to store and blender
    scan_pos_t  scan_pos;
    sync_t      sync;
    fb_bytes_t  rd_bytes;

    frame_capture u_capture
    (
        .clk_sys         (clk_sys),
        .reset           (reset),
        .frame_complete  (frame_complete),
        .lcd_read        (lcd_read),
        .lcd_read_column (lcd_read_column),
        .fb_we           (fb_we),
        .fb_wr_addr      (fb_wr_addr),
        .fb_wr_index     (fb_wr_index),
        .fb_wr_data      (fb_wr_data)
    );

    frame_store u_store
    (
        .clk_sys     (clk_sys),
        .fb_we       (fb_we),
        .fb_wr_addr  (fb_wr_addr),
        .fb_wr_index (fb_wr_index),
        .fb_wr_data  (fb_wr_data),
        .rd_pos      (scan_pos),
        .rd_bytes    (rd_bytes)
    );

    video_timing u_timing
    (
        .clk_sys  (clk_sys),
        .reset    (reset),
        .ce_pix   (ce_pix),
        .scan_pos (scan_pos),
        .sync     (sync)
    );

    pixel_blender u_blender
    (
        .clk_sys      (clk_sys),
        .reset        (reset),
        .scan_pos     (scan_pos),
        .sync         (sync),
        .rd_bytes     (rd_bytes),
        .lcd_contrast (lcd_contrast),
        .video        (video)
    );

endmodule

//--- src/pixel_blender.sv
`timescale 1ns/1ps

`include "lcd_video_cfg.svh"

module pixel_blender
(
    input  logic                      clk_sys,
    input  logic                      reset,
    input  lcd_video_pkg::scan_pos_t  scan_pos,
    input  lcd_video_pkg::sync_t      sync,
    input  lcd_video_pkg::fb_bytes_t  rd_bytes,
    input  logic [5:0]                lcd_contrast,
    output lcd_video_pkg::video_out_t video
);
    import lcd_video_pkg::*;

    localparam sync_t sync_blank = '{hs: 1'b0, vs: 1'b0, hbl: 1'b1, vbl: 1'b1};

    scan_pos_t  pos_d;
    sync_t      sync_d;
    logic [7:0] brightness;
    logic [9:0] level_sum;

    // Full level once contrast saturates
    assign brightness = (lcd_contrast >= `CONTRAST_SAT) ? 8'd255 : {lcd_contrast[4:0], 3'b000};

    // A cleared bit is a dark pixel and adds the brightness
    always_comb
    begin
        level_sum = '0;
        for (int i = 0; i < `FB_COUNT; i++)
        begin
            if (!rd_bytes[i][pos_d.y[2:0]])
                level_sum = level_sum + 10'(brightness);
        end
    end

    ////////////////////////////////////////////////////////////
    // Store latency match and output register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_sys)
    begin
        if (reset)
        begin
            pos_d  <= '0;
            sync_d <= sync_blank;
            video  <= '{sync: sync_blank, de: 1'b0, level: 8'd0};
        end
        else
        begin
            pos_d       <= scan_pos;
            sync_d      <= sync;
            video.sync  <= sync_d;
            video.de    <= pos_d.active;
            // Average over the four buffers
            video.level <= level_sum[9:2];
        end
    end

endmodule

//--- src/video_timing.sv
`timescale 1ns/1ps

`include "lcd_video_cfg.svh"

module video_timing
(
    input  logic                     clk_sys,
    input  logic                     reset,
    output logic                     ce_pix,
    output lcd_video_pkg::scan_pos_t scan_pos,
    output lcd_video_pkg::sync_t     sync
);

    localparam logic [7:0] h_last      = 8'(`H_TOTAL - 1);
    localparam logic [6:0] v_last      = 7'(`V_TOTAL - 1);
    localparam logic [7:0] h_act_start = 8'(`H_ACT_START);
    localparam logic [7:0] h_act_end   = 8'(`H_ACT_END);
    localparam logic [6:0] v_act_start = 7'(`V_ACT_START);
    localparam logic [6:0] v_act_end   = 7'(`V_ACT_END);
    localparam logic [7:0] hs_start    = 8'(`HS_START);
    localparam logic [7:0] hs_end      = 8'(`HS_END);
    localparam logic [6:0] vs_start    = 7'(`VS_START);
    localparam logic [6:0] vs_end      = 7'(`VS_END);
    localparam logic [6:0] x_last      = 7'(`LCD_XSIZE - 1);

    logic [1:0] prescale;
    logic [7:0] hpos;
    logic [6:0] vpos;
    logic [6:0] xpos;
    logic [5:0] ypos;
    logic       hs;
    logic       vs;
    logic       hbl;
    logic       vbl;

    // One pixel every fourth clock
    assign ce_pix = &prescale;

    assign sync     = '{hs: hs, vs: vs, hbl: hbl, vbl: vbl};
    assign scan_pos = '{x: xpos, y: ypos, active: ~(hbl | vbl)};

    always_ff @(posedge clk_sys)
    begin
        if (reset)
            prescale <= '0;
        else
            prescale <= prescale + 2'd1;
    end

    ////////////////////////////////////////////////////////////
    // Raster counters, blanking and sync
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_sys)
    begin
        if (reset)
        begin
            hpos <= '0;
            vpos <= '0;
            hs   <= 1'b0;
            vs   <= 1'b0;
            hbl  <= 1'b1;
            vbl  <= 1'b1;
        end
        else if (ce_pix)
        begin
            if (hpos == h_act_end)
                hbl <= 1'b1;
            else if (hpos == h_act_start)
                hbl <= 1'b0;

            if (vpos >= v_act_end)
                vbl <= 1'b1;
            else if (vpos == v_act_start)
                vbl <= 1'b0;

            // Vsync edges line up with the start of hsync
            if (hpos == hs_start)
            begin
                hs <= 1'b1;
                if (vpos == vs_start)
                    vs <= 1'b1;
                else if (vpos == vs_end)
                    vs <= 1'b0;
            end
            else if (hpos == hs_end)
                hs <= 1'b0;

            if (hpos == h_last)
            begin
                hpos <= '0;
                vpos <= (vpos == v_last) ? 7'd0 : vpos + 7'd1;
            end
            else
                hpos <= hpos + 8'd1;
        end
    end

    // Window position, held at zero through vertical blank
    always_ff @(posedge clk_sys)
    begin
        if (reset || (ce_pix && vbl))
        begin
            xpos <= '0;
            ypos <= '0;
        end
        else if (ce_pix && !hbl)
        begin
            if (xpos == x_last)
            begin
                xpos <= '0;
                ypos <= ypos + 6'd1;
            end
            else
                xpos <= xpos + 7'd1;
        end
    end

endmodule

//--- src/frame_store.sv
`timescale 1ns/1ps

`include "lcd_video_cfg.svh"

module frame_store
(
    input  logic                     clk_sys,
    input  logic                     fb_we,
    input  lcd_video_pkg::lcd_addr_t fb_wr_addr,
    input  logic [1:0]               fb_wr_index,
    input  logic [7:0]               fb_wr_data,
    input  lcd_video_pkg::scan_pos_t rd_pos,
    output lcd_video_pkg::fb_bytes_t rd_bytes
);

    logic [7:0] fb_mem [`FB_COUNT][`FB_DEPTH];
    logic [9:0] wr_lin;
    logic [9:0] rd_lin;

    // Byte row major, one row of LCD_XSIZE columns after another
    function automatic logic [9:0] lin_addr(input logic [2:0] row, input logic [6:0] col);
        return 10'(row) * 10'(`LCD_XSIZE) + 10'(col);
    endfunction

    assign wr_lin = lin_addr(fb_wr_addr.row, fb_wr_addr.col);

    // Eight display lines share one byte row
    assign rd_lin = lin_addr(rd_pos.y[5:3], rd_pos.x);

    ////////////////////////////////////////////////////////////
    // One write port, all buffers read in parallel
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_sys)
    begin
        if (fb_we)
        begin
            fb_mem[fb_wr_index][wr_lin] <= fb_wr_data;
        end

        for (int i = 0; i < `FB_COUNT; i++)
        begin
            rd_bytes[i] <= fb_mem[i][rd_lin];
        end
    end

endmodule

//--- src/frame_capture.sv
`timescale 1ns/1ps

`include "lcd_video_cfg.svh"

module frame_capture
(
    input  logic                     clk_sys,
    input  logic                     reset,
    input  logic                     frame_complete,
    output lcd_video_pkg::lcd_addr_t lcd_read,
    input  logic [7:0]               lcd_read_column,
    output logic                     fb_we,
    output lcd_video_pkg::lcd_addr_t fb_wr_addr,
    output logic [1:0]               fb_wr_index,
    output logic [7:0]               fb_wr_data
);
    import lcd_video_pkg::*;

    localparam logic [6:0] col_last = 7'(`LCD_XSIZE - 1);
    localparam logic [2:0] row_last = 3'(`LCD_COLS - 1);

    capture_state_t state;
    lcd_addr_t      rd_addr;
    logic           phase;
    logic [1:0]     wr_index;

    // LCD answers combinationally, so the byte is written at the read address
    assign lcd_read    = rd_addr;
    assign fb_wr_addr  = rd_addr;
    assign fb_wr_data  = lcd_read_column;
    assign fb_wr_index = wr_index;
    assign fb_we       = (state == CAP_COPY) && phase;

    // Copy runs at half the system clock
    always_ff @(posedge clk_sys)
    begin
        if (reset)
            phase <= 1'b0;
        else
            phase <= ~phase;
    end

    ////////////////////////////////////////////////////////////
    // Copy FSM
    ////////////////////////////////////////////////////////////

    // CAP_COPY holds the strobe, so a strobe during a copy merges into it
    always_ff @(posedge clk_sys)
    begin
        if (reset)
        begin
            state    <= CAP_IDLE;
            rd_addr  <= '0;
            wr_index <= '0;
        end
        else
        begin
            case (state)
                CAP_IDLE:
                begin
                    if (frame_complete)
                        state <= CAP_COPY;
                end
                CAP_COPY:
                begin
                    if (phase)
                    begin
                        if (rd_addr.col == col_last)
                        begin
                            rd_addr.col <= '0;
                            rd_addr.row <= rd_addr.row + 3'd1;
                            // Last byte row done, next buffer in turn
                            if (rd_addr.row == row_last)
                            begin
                                wr_index <= wr_index + 2'd1;
                                state    <= CAP_IDLE;
                            end
                        end
                        else
                            rd_addr.col <= rd_addr.col + 7'd1;
                    end
                end
                default:
                    state <= CAP_IDLE;
            endcase
        end
    end

endmodule

//--- src/lcd_video_pkg.sv
`include "lcd_video_cfg.svh"

package lcd_video_pkg;

    // LCD read request, column inside a byte row
    typedef struct packed {
        logic [6:0] col;
        logic [2:0] row;
    } lcd_addr_t;

    // Position inside the active window
    typedef struct packed {
        logic [6:0] x;
        logic [5:0] y;
        logic       active;
    } scan_pos_t;

    typedef struct packed {
        logic hs;
        logic vs;
        logic hbl;
        logic vbl;
    } sync_t;

    // One byte from each frame buffer, index 0 in the low byte
    typedef logic [`FB_COUNT-1:0][7:0] fb_bytes_t;

    typedef struct packed {
        sync_t      sync;
        logic       de;
        logic [7:0] level;
    } video_out_t;

    typedef enum logic {
        CAP_IDLE,
        CAP_COPY
    } capture_state_t;

endpackage

//--- src/lcd_video_cfg.svh
`ifndef LCD_VIDEO_CFG_SVH
`define LCD_VIDEO_CFG_SVH

////////////////////////////////////////////////////////////
// LCD geometry
////////////////////////////////////////////////////////////

`define LCD_XSIZE    96
`define LCD_YSIZE    64
// Each byte holds 8 vertical pixels
`define LCD_COLS     8
`define FB_DEPTH     (`LCD_XSIZE * `LCD_COLS)
`define FB_COUNT     4

////////////////////////////////////////////////////////////
// Raster timing, in pixels and lines
////////////////////////////////////////////////////////////

`define H_TOTAL      140
`define V_TOTAL      119
`define H_ACT_START  16
`define H_ACT_END    (`H_ACT_START + `LCD_XSIZE)
`define V_ACT_START  32
`define V_ACT_END    (`V_ACT_START + `LCD_YSIZE)
`define HS_START     120
`define HS_END       136
`define VS_START     1
`define VS_END       4

// Contrast at or above this gives full brightness
`define CONTRAST_SAT 6'h20

`endif
